/* Bender.yml */
package:
  name: asa_stage

sources:
  - files:
      - hdl/asa_pkg.sv
      - hdl/ram_1r1w.sv
      - hdl/ras_decode.sv
      - hdl/asa_tables.sv
      - hdl/forward_decide.sv
      - hdl/asa_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/asa_assertions.sv
      - tb/asa_tb.sv

/* hdl/asa_pkg.sv */
//##########################################################################
// Shared types of the action-set stage. Eight egress ports and the field
// widths are fixed here. The fid_bits and tid_bits module parameters must
// stay equal to the widths of fid_t and tid_t.
//##########################################################################
`default_nettype none

package asa_pkg;

	typedef logic [2:0] sci_t;
	typedef logic [7:0] sci_vec_t;
	typedef logic [3:0] fid_t;
	typedef logic [3:0] tid_t;
	typedef logic [1:0] pri_t;
	typedef logic [15:0] time_t;
	typedef logic [7:0] sub_time_t;
	typedef logic [3:0] port_t;
	typedef logic [11:0] buf_ptr_t;
	typedef logic [3:0] domain_t;
	typedef logic [2:0] tclass_t;
	typedef logic [1:0] def_type_t;
	typedef logic [15:0] class_pri_t;
	typedef logic [6:0] tset_addr_t;

	typedef struct packed {
		logic invalid;
		sci_t sci;
	} ras_entry_t;

	// A cleared keep_flow means the classifier terminated the flow.
	typedef struct packed {
		logic keep_flow;
		logic exec_flow;
		logic exec_topic;
		logic allow_update;
		logic set_default;
		def_type_t default_type;
	} ras_flags_t;

	typedef struct packed {
		ras_flags_t flags;
		ras_entry_t [7:0] flow;
		ras_entry_t topic;
	} ras_t;

	typedef struct packed {
		fid_t fid;
		tid_t tid;
		sci_t rci;
		port_t src_port;
		port_t dst_port;
		buf_ptr_t buf_ptr;
		logic type1;
		domain_t domain_id;
		logic discard;
	} meta_t;

	typedef struct packed {
		logic allow_update_fas;
		logic allow_update_tas;
		logic allow_exec_forward;
		logic allow_fsas_forward;
		logic allow_tsas_forward;
		logic allow_mcast;
		logic allow_supervisor;
	} mask_on_t;

	typedef struct packed {
		domain_t domain_id;
		tclass_t tclass;
		mask_on_t mask_on;
	} policy_t;

	typedef struct packed {
		def_type_t default_type;
		sci_vec_t action_set;
	} action_t;

	typedef struct packed {
		port_t src_port;
		port_t dst_port;
		buf_ptr_t buf_ptr;
	} desc_t;

	typedef struct packed {
		sci_vec_t flow_vec;
		sci_vec_t topic_vec;
		logic flow_vec_any;
		logic topic_valid;
		sci_t topic_sci;
		ras_flags_t flags;
	} decode_t;

	function automatic sci_vec_t sci_onehot(input sci_t sci);
		sci_vec_t v;
		v = '0;
		v[sci] = 1'b1;
		return v;
	endfunction

endpackage

`default_nettype wire

/* hdl/asa_tables.sv */
//##########################################################################
// Policy, flow action and topic action tables. Table writes are forwarded
// to the two reads in flight, so packets see the updates of the packets
// ahead of them. Policy writes are not forwarded.
//##########################################################################
`default_nettype none

module asa_tables
	import asa_pkg::*;
#(
	parameter int fid_bits = 4,
	parameter int tid_bits = 4
) (
	input wire clk,
	input wire reset,
	input wire policy_wr,
	input wire [fid_bits-1:0] policy_addr,
	input wire policy_t policy_data,
	input wire rd,
	input wire [fid_bits-1:0] rd_fid,
	input wire [tid_bits-1:0] rd_tid,
	input wire fa_wr,
	input wire [fid_bits-1:0] fa_waddr,
	input wire action_t fa_wdata,
	input wire ta_wr,
	input wire [tid_bits-1:0] ta_waddr,
	input wire sci_vec_t ta_wdata,
	output policy_t policy,
	output action_t flow_action,
	output sci_vec_t topic_action
);

	logic policy_wr_d;
	logic [fid_bits-1:0] policy_addr_d;
	policy_t policy_data_d;
	action_t fa_ram;
	sci_vec_t ta_ram;
	logic [fid_bits-1:0] fid1;
	logic [tid_bits-1:0] tid1;
	logic fa_hit1;
	logic ta_hit1;
	action_t fa_fwd1;
	sci_vec_t ta_fwd1;

	ram_1r1w #(.width($bits(policy_t)), .addr_bits(fid_bits)) policy_ram (
		.clk(clk),
		.wr(policy_wr_d),
		.waddr(policy_addr_d),
		.din(policy_data_d),
		.raddr(rd_fid),
		.dout(policy)
	);

	ram_1r1w #(.width($bits(action_t)), .addr_bits(fid_bits)) flow_ram (
		.clk(clk),
		.wr(fa_wr),
		.waddr(fa_waddr),
		.din(fa_wdata),
		.raddr(rd_fid),
		.dout(fa_ram)
	);

	ram_1r1w #(.width($bits(sci_vec_t)), .addr_bits(tid_bits)) topic_ram (
		.clk(clk),
		.wr(ta_wr),
		.waddr(ta_waddr),
		.din(ta_wdata),
		.raddr(rd_tid),
		.dout(ta_ram)
	);

	// A write in the same cycle as a read leaves the RAM output stale,
	// so the written data is kept for that read's data cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			policy_wr_d <= 1'b0;
			fa_hit1 <= 1'b0;
			ta_hit1 <= 1'b0;
		end else begin
			policy_wr_d <= policy_wr;
			fa_hit1 <= rd && fa_wr && (fa_waddr == rd_fid);
			ta_hit1 <= rd && ta_wr && (ta_waddr == rd_tid);
		end
	end

	always_ff @(posedge clk) begin
		policy_addr_d <= policy_addr;
		policy_data_d <= policy_data;
		fid1 <= rd_fid;
		tid1 <= rd_tid;
		fa_fwd1 <= fa_wdata;
		ta_fwd1 <= ta_wdata;
	end

	// The write of the current cycle is newer than the kept one.
	always_comb begin
		flow_action = fa_hit1 ? fa_fwd1 : fa_ram;
		if (fa_wr && (fa_waddr == fid1)) begin
			flow_action = fa_wdata;
		end
		topic_action = ta_hit1 ? ta_fwd1 : ta_ram;
		if (ta_wr && (ta_waddr == tid1)) begin
			topic_action = ta_wdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/asa_top.sv */
//##########################################################################
// Action-set stage. One packet per cycle, outputs three cycles after the
// input strobe. Configuration inputs must be held stable.
//##########################################################################
`default_nettype none

module asa_top
	import asa_pkg::*;
#(
	parameter int fid_bits = 4,
	parameter int tid_bits = 4
) (
	input wire clk,
	input wire reset,
	input wire policy_wr,
	input wire [fid_bits-1:0] policy_addr,
	input wire policy_t policy_data,
	input wire sci_t supervisor_sci,
	input wire class_pri_t class2pri,
	input wire sub_time_t default_sub_exp_time,
	input wire time_t current_time,
	input wire in_valid,
	input wire in_type3,
	input wire meta_t in_meta,
	input wire ras_t in_ras,
	output logic enq_req,
	output logic enq_discard,
	output logic enq_allow_mcast,
	output sci_vec_t enq_vec,
	output pri_t enq_pri,
	output desc_t enq_desc,
	output tid_t enq_tid,
	output logic tset_wr,
	output tset_addr_t tset_addr,
	output sub_time_t tset_data,
	output logic cls_valid,
	output fid_t cls_fid
);

	decode_t dec;
	logic dec_valid;
	logic dec_type3;
	meta_t dec_meta;
	sci_vec_t ingress_mask;
	policy_t policy;
	action_t flow_action;
	sci_vec_t topic_action;
	logic fa_wr;
	logic [fid_bits-1:0] fa_waddr;
	action_t fa_wdata;
	logic ta_wr;
	logic [tid_bits-1:0] ta_waddr;
	sci_vec_t ta_wdata;

	ras_decode decode (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_type3(in_type3),
		.in_meta(in_meta),
		.in_ras(in_ras),
		.dec(dec),
		.dec_valid(dec_valid),
		.dec_type3(dec_type3),
		.dec_meta(dec_meta),
		.ingress_mask(ingress_mask)
	);

	asa_tables #(.fid_bits(fid_bits), .tid_bits(tid_bits)) tables (
		.clk(clk),
		.reset(reset),
		.policy_wr(policy_wr),
		.policy_addr(policy_addr),
		.policy_data(policy_data),
		.rd(in_valid),
		.rd_fid(in_meta.fid),
		.rd_tid(in_meta.tid),
		.fa_wr(fa_wr),
		.fa_waddr(fa_waddr),
		.fa_wdata(fa_wdata),
		.ta_wr(ta_wr),
		.ta_waddr(ta_waddr),
		.ta_wdata(ta_wdata),
		.policy(policy),
		.flow_action(flow_action),
		.topic_action(topic_action)
	);

	forward_decide #(.fid_bits(fid_bits), .tid_bits(tid_bits)) decide (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.dec_valid(dec_valid),
		.dec_type3(dec_type3),
		.dec_meta(dec_meta),
		.ingress_mask(ingress_mask),
		.policy(policy),
		.flow_action(flow_action),
		.topic_action(topic_action),
		.supervisor_sci(supervisor_sci),
		.class2pri(class2pri),
		.current_time(current_time),
		.default_sub_exp_time(default_sub_exp_time),
		.fa_wr(fa_wr),
		.fa_waddr(fa_waddr),
		.fa_wdata(fa_wdata),
		.ta_wr(ta_wr),
		.ta_waddr(ta_waddr),
		.ta_wdata(ta_wdata),
		.cls_valid(cls_valid),
		.cls_fid(cls_fid),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.enq_tid(enq_tid),
		.tset_wr(tset_wr),
		.tset_addr(tset_addr),
		.tset_data(tset_data)
	);

endmodule

`default_nettype wire

/* hdl/forward_decide.sv */
//##########################################################################
// Forwarding decision. Table updates are registered from the read cycle
// and commit one cycle later; the enqueue and timer outputs follow a
// further cycle after that. There is no back-pressure.
//##########################################################################
`default_nettype none

module forward_decide
	import asa_pkg::*;
#(
	parameter int fid_bits = 4,
	parameter int tid_bits = 4
) (
	input wire clk,
	input wire reset,
	input wire decode_t dec,
	input wire dec_valid,
	input wire dec_type3,
	input wire meta_t dec_meta,
	input wire sci_vec_t ingress_mask,
	input wire policy_t policy,
	input wire action_t flow_action,
	input wire sci_vec_t topic_action,
	input wire sci_t supervisor_sci,
	input wire class_pri_t class2pri,
	input wire time_t current_time,
	input wire sub_time_t default_sub_exp_time,
	output logic fa_wr,
	output logic [fid_bits-1:0] fa_waddr,
	output action_t fa_wdata,
	output logic ta_wr,
	output logic [tid_bits-1:0] ta_waddr,
	output sci_vec_t ta_wdata,
	output logic cls_valid,
	output fid_t cls_fid,
	output logic enq_req,
	output logic enq_discard,
	output logic enq_allow_mcast,
	output sci_vec_t enq_vec,
	output pri_t enq_pri,
	output desc_t enq_desc,
	output tid_t enq_tid,
	output logic tset_wr,
	output tset_addr_t tset_addr,
	output sub_time_t tset_data
);

	logic drop;
	logic learn;
	logic fa_vec_wr;
	logic fa_def_wr;
	logic ta_learn;
	action_t fa_next;

	logic valid_d;
	logic type3_d;
	logic drop_d;
	meta_t meta_d;
	decode_t dec_d;
	policy_t policy_d;
	action_t fa_d;
	sci_vec_t ta_d;
	sci_vec_t mask_d;
	time_t time_d;

	logic use_eflow;
	sci_vec_t vec_std;
	sci_vec_t vec_type3;
	sci_vec_t sup_mask;
	logic discard;
	time_t exp_time;

	// Update decision, taken on the table data of the read cycle.
	always_comb begin
		drop = dec_meta.discard || (dec_meta.type1 && (dec_meta.domain_id != '0) &&
			(dec_meta.domain_id != policy.domain_id));
		learn = dec_valid && !dec_type3 && !drop && dec.flags.keep_flow;
		fa_vec_wr = learn && dec.flags.exec_flow && dec.flags.allow_update &&
			policy.mask_on.allow_update_fas && dec.flow_vec_any;
		fa_def_wr = learn && dec.flags.set_default && policy.mask_on.allow_update_fas;
		ta_learn = learn && dec.flags.exec_topic && dec.topic_valid &&
			policy.mask_on.allow_update_tas;
		fa_next.default_type = fa_def_wr ? dec.flags.default_type : flow_action.default_type;
		fa_next.action_set = fa_vec_wr ? dec.flow_vec : flow_action.action_set;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fa_wr <= 1'b0;
			ta_wr <= 1'b0;
			cls_valid <= 1'b0;
			valid_d <= 1'b0;
			enq_req <= 1'b0;
			tset_wr <= 1'b0;
		end else begin
			fa_wr <= fa_vec_wr || fa_def_wr;
			ta_wr <= ta_learn;
			cls_valid <= dec_valid && dec.flags.keep_flow;
			valid_d <= dec_valid;
			enq_req <= valid_d;
			tset_wr <= ta_wr;
		end
	end

	always_ff @(posedge clk) begin
		fa_waddr <= dec_meta.fid;
		fa_wdata <= fa_next;
		ta_waddr <= dec_meta.tid;
		ta_wdata <= topic_action | dec.topic_vec;
		cls_fid <= dec_meta.tid;
		type3_d <= dec_type3;
		drop_d <= drop;
		meta_d <= dec_meta;
		dec_d <= dec;
		policy_d <= policy;
		fa_d <= flow_action;
		ta_d <= topic_action;
		mask_d <= ingress_mask;
		time_d <= current_time;
	end

	// Forwarding uses the stored actions as they were before this packet's update.
	always_comb begin
		use_eflow = dec_d.flags.exec_flow && dec_d.flags.allow_update &&
			policy_d.mask_on.allow_exec_forward;
		vec_std = '0;
		if (dec_d.flags.exec_topic && policy_d.mask_on.allow_exec_forward) begin
			vec_std = vec_std | dec_d.topic_vec;
		end
		if (use_eflow) begin
			vec_std = vec_std | dec_d.flow_vec;
		end
		if (dec_d.flags.exec_topic && policy_d.mask_on.allow_tsas_forward) begin
			vec_std = vec_std | ta_d;
		end
		if (policy_d.mask_on.allow_fsas_forward && !use_eflow) begin
			vec_std = vec_std | fa_d.action_set;
		end
		vec_type3 = '0;
		if (fa_d.default_type[0] && policy_d.mask_on.allow_tsas_forward) begin
			vec_type3 = vec_type3 | ta_d;
		end
		if (fa_d.default_type[1] && policy_d.mask_on.allow_fsas_forward) begin
			vec_type3 = vec_type3 | fa_d.action_set;
		end
		sup_mask = policy_d.mask_on.allow_supervisor ? '1 : ~sci_onehot(supervisor_sci);
		if (type3_d) begin
			discard = drop_d || (fa_d.default_type == 2'b00);
		end else begin
			discard = drop_d || !(dec_d.flags.exec_flow || dec_d.flags.exec_topic);
		end
		exp_time = time_d + {default_sub_exp_time, 8'h00};
	end

	always_ff @(posedge clk) begin
		enq_discard <= discard;
		enq_allow_mcast <= policy_d.mask_on.allow_mcast;
		enq_vec <= (type3_d ? vec_type3 : vec_std) & mask_d & sup_mask;
		enq_pri <= class2pri[2 * policy_d.tclass +: 2];
		enq_desc.src_port <= meta_d.src_port;
		enq_desc.dst_port <= meta_d.dst_port;
		enq_desc.buf_ptr <= meta_d.buf_ptr;
		enq_tid <= meta_d.tid;
		tset_addr <= {meta_d.tid, dec_d.topic_sci};
		tset_data <= exp_time[15:8];
	end

endmodule

`default_nettype wire

/* hdl/ram_1r1w.sv */
//##########################################################################
// One-read one-write RAM with a registered read, cleared at start-up.
// A read of the address being written returns the old data.
//##########################################################################
`default_nettype none

module ram_1r1w #(
	parameter int width = 8,
	parameter int addr_bits = 4
) (
	input wire clk,
	input wire wr,
	input wire [addr_bits-1:0] waddr,
	input wire [width-1:0] din,
	input wire [addr_bits-1:0] raddr,
	output logic [width-1:0] dout
);

	logic [width-1:0] mem [2**addr_bits] = '{default: '0};

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

/* hdl/ras_decode.sv */
//##########################################################################
// Decodes the rule action set into port vectors one cycle after the
// packet strobe. Invalid entries contribute no port.
//##########################################################################
`default_nettype none

module ras_decode
	import asa_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire in_type3,
	input wire meta_t in_meta,
	input wire ras_t in_ras,
	output decode_t dec,
	output logic dec_valid,
	output logic dec_type3,
	output meta_t dec_meta,
	output sci_vec_t ingress_mask
);

	sci_vec_t flow_or;
	logic [7:0] flow_valid;
	decode_t dec_next;

	always_comb begin
		flow_or = '0;
		for (int i = 0; i < 8; i++) begin
			flow_valid[i] = !in_ras.flow[i].invalid;
			if (flow_valid[i]) begin
				flow_or = flow_or | sci_onehot(in_ras.flow[i].sci);
			end
		end
	end

	always_comb begin
		dec_next.flow_vec = flow_or;
		dec_next.flow_vec_any = |flow_valid;
		dec_next.topic_valid = !in_ras.topic.invalid;
		dec_next.topic_vec = in_ras.topic.invalid ? '0 : sci_onehot(in_ras.topic.sci);
		dec_next.topic_sci = in_ras.topic.sci;
		dec_next.flags = in_ras.flags;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= in_valid;
		end
	end

	// The packet may not be sent back out of the port it came in on.
	always_ff @(posedge clk) begin
		dec <= dec_next;
		dec_type3 <= in_type3;
		dec_meta <= in_meta;
		ingress_mask <= ~sci_onehot(in_meta.rci);
	end

endmodule

`default_nettype wire

/* tb.f */
hdl/asa_pkg.sv
hdl/ram_1r1w.sv
hdl/ras_decode.sv
hdl/asa_tables.sv
hdl/forward_decide.sv
hdl/asa_top.sv
tb/tb_clock_gen.sv
tb/asa_assertions.sv
tb/asa_tb.sv

/* tb/asa_assertions.sv */
//##########################################################################
// Timing checks on the forwarding decision, bound to forward_decide.
// Latency is counted from the decode strobe, one cycle after in_valid.
//##########################################################################
`default_nettype none

module asa_assertions (
	input wire clk,
	input wire reset,
	input wire dec_valid,
	input wire enq_req,
	input wire enq_discard,
	input wire tset_wr,
	input wire cls_valid
);

	int fail_count = 0;

	// The enqueue request comes two cycles after the decode strobe.
	property enq_latency;
		@(posedge clk) disable iff (reset) enq_req == $past(dec_valid, 2);
	endproperty

	// A timer write belongs to a packet that is forwarded.
	property tset_forwarded;
		@(posedge clk) disable iff (reset) tset_wr |-> enq_req && !enq_discard;
	endproperty

	property quiet_in_reset;
		@(posedge clk) reset |=> !enq_req && !tset_wr && !cls_valid;
	endproperty

	assert property (enq_latency)
	else begin
		$error("enq_req does not follow in_valid by three cycles");
		fail_count++;
	end

	assert property (tset_forwarded)
	else begin
		$error("tset_wr set without a forwarded enqueue request");
		fail_count++;
	end

	assert property (quiet_in_reset)
	else begin
		$error("output strobe set during reset");
		fail_count++;
	end

endmodule

`default_nettype wire

/* tb/asa_tb.sv */
//##########################################################################
// Random testbench of the action-set stage. A model of the three tables
// predicts every output; packets are checked in order at fixed latency.
//##########################################################################
`default_nettype none

module asa_tb;
	import asa_pkg::*;

	localparam int num_packets = 40;
	localparam int test_cycles = 10 + 6 * (16 + 2 + 2 * num_packets + 4) + 2;
	localparam int max_cycles = test_cycles + 200;
	localparam time_t time_step = 16'd97;

	typedef struct packed {
		logic valid;
		logic discard;
		logic allow_mcast;
		sci_vec_t vec;
		pri_t pri;
		desc_t desc;
		tid_t tid;
		logic tset_wr;
		tset_addr_t tset_addr;
		sub_time_t tset_data;
		logic cls_valid;
		fid_t cls_fid;
	} expect_t;

	logic clk;
	logic reset;
	logic policy_wr;
	fid_t policy_addr;
	policy_t policy_data;
	sci_t supervisor_sci;
	class_pri_t class2pri;
	sub_time_t default_sub_exp_time;
	time_t current_time;
	logic in_valid;
	logic in_type3;
	meta_t in_meta;
	ras_t in_ras;
	logic enq_req;
	logic enq_discard;
	logic enq_allow_mcast;
	sci_vec_t enq_vec;
	pri_t enq_pri;
	desc_t enq_desc;
	tid_t enq_tid;
	logic tset_wr;
	tset_addr_t tset_addr;
	sub_time_t tset_data;
	logic cls_valid;
	fid_t cls_fid;

	int seed = 32'h6924;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	policy_t pol_m [16];
	action_t fa_m [16];
	sci_vec_t ta_m [16];
	expect_t pending [$];
	mask_on_t no_bits;
	mask_on_t fas_bits;
	mask_on_t tas_bits;
	mask_on_t learn_bits;

	tb_clock_gen #(.period(40)) clock (
		.clk(clk)
	);

	asa_top #(.fid_bits(4), .tid_bits(4)) UUT (
		.clk(clk),
		.reset(reset),
		.policy_wr(policy_wr),
		.policy_addr(policy_addr),
		.policy_data(policy_data),
		.supervisor_sci(supervisor_sci),
		.class2pri(class2pri),
		.default_sub_exp_time(default_sub_exp_time),
		.current_time(current_time),
		.in_valid(in_valid),
		.in_type3(in_type3),
		.in_meta(in_meta),
		.in_ras(in_ras),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.enq_tid(enq_tid),
		.tset_wr(tset_wr),
		.tset_addr(tset_addr),
		.tset_data(tset_data),
		.cls_valid(cls_valid),
		.cls_fid(cls_fid)
	);

	bind forward_decide asa_assertions checks (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.tset_wr(tset_wr),
		.cls_valid(cls_valid)
	);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: the run went past %0d cycles", max_cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at time %0t: %s is %0h, expected %0h", $time, name, actual,
				expected);
		end
	endtask

	// Enqueue outputs belong to the packet of three steps ago, cls to two.
	task automatic compare_outputs();
		expect_t e;
		expect_t c;
		e = pending[0];
		c = pending[1];
		compare("enq_req", enq_req, e.valid);
		if (e.valid) begin
			compare("enq_discard", enq_discard, e.discard);
			compare("enq_allow_mcast", enq_allow_mcast, e.allow_mcast);
			compare("enq_vec", enq_vec, e.vec);
			compare("enq_pri", enq_pri, e.pri);
			compare("enq_desc", enq_desc, e.desc);
			compare("enq_tid", enq_tid, e.tid);
		end
		compare("tset_wr", tset_wr, e.tset_wr);
		if (e.tset_wr) begin
			compare("tset_addr", tset_addr, e.tset_addr);
			compare("tset_data", tset_data, e.tset_data);
		end
		compare("cls_valid", cls_valid, c.cls_valid);
		if (c.cls_valid) begin
			compare("cls_fid", cls_fid, c.cls_fid);
		end
	endtask

	// Predicts one packet and applies its table updates, in packet order.
	task automatic model_packet(input logic type3, input meta_t m, input ras_t r,
			input time_t t1, output expect_t e);
		policy_t p;
		action_t fa;
		sci_vec_t ta;
		sci_vec_t flow_vec;
		sci_vec_t topic_vec;
		sci_vec_t vec;
		sci_vec_t sup_mask;
		logic flow_any;
		logic drop;
		logic learn;
		logic eflow;
		time_t expiry;
		e = '0;
		p = pol_m[m.fid];
		fa = fa_m[m.fid];
		ta = ta_m[m.tid];
		flow_vec = '0;
		flow_any = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (!r.flow[i].invalid) begin
				flow_vec[r.flow[i].sci] = 1'b1;
				flow_any = 1'b1;
			end
		end
		topic_vec = r.topic.invalid ? 8'h00 : (8'h01 << r.topic.sci);
		drop = m.discard || (m.type1 && m.domain_id != 4'h0 && m.domain_id != p.domain_id);
		learn = !type3 && !drop && r.flags.keep_flow;
		eflow = r.flags.exec_flow && r.flags.allow_update && p.mask_on.allow_exec_forward;
		vec = '0;
		if (type3) begin
			if (fa.default_type[0] && p.mask_on.allow_tsas_forward)
				vec = vec | ta;
			if (fa.default_type[1] && p.mask_on.allow_fsas_forward)
				vec = vec | fa.action_set;
			e.discard = drop || fa.default_type == 2'd0;
		end else begin
			if (r.flags.exec_topic && p.mask_on.allow_exec_forward)
				vec = vec | topic_vec;
			if (eflow)
				vec = vec | flow_vec;
			if (r.flags.exec_topic && p.mask_on.allow_tsas_forward)
				vec = vec | ta;
			if (p.mask_on.allow_fsas_forward && !eflow)
				vec = vec | fa.action_set;
			e.discard = drop || !(r.flags.exec_flow || r.flags.exec_topic);
		end
		sup_mask = p.mask_on.allow_supervisor ? 8'hff : ~(8'h01 << supervisor_sci);
		e.valid = 1'b1;
		e.allow_mcast = p.mask_on.allow_mcast;
		e.vec = vec & ~(8'h01 << m.rci) & sup_mask;
		e.pri = pri_t'(class2pri >> (2 * p.tclass));
		e.desc = {m.src_port, m.dst_port, m.buf_ptr};
		e.tid = m.tid;
		e.tset_wr = learn && r.flags.exec_topic && !r.topic.invalid &&
			p.mask_on.allow_update_tas;
		e.tset_addr = {m.tid, r.topic.sci};
		expiry = t1 + {default_sub_exp_time, 8'h00};
		e.tset_data = expiry[15:8];
		e.cls_valid = r.flags.keep_flow;
		e.cls_fid = m.tid;
		if (learn && p.mask_on.allow_update_fas) begin
			if (r.flags.exec_flow && r.flags.allow_update && flow_any)
				fa_m[m.fid].action_set = flow_vec;
			if (r.flags.set_default)
				fa_m[m.fid].default_type = r.flags.default_type;
		end
		if (e.tset_wr)
			ta_m[m.tid] = ta | topic_vec;
	endtask

	// Checks the outputs of one clock cycle, then drives the next inputs.
	task automatic step(input logic valid, input logic type3, input meta_t m,
			input ras_t r);
		expect_t e;
		@(negedge clk);
		compare_outputs();
		current_time = current_time + time_step;
		e = '0;
		if (valid)
			model_packet(type3, m, r, current_time + time_step, e);
		policy_wr = 1'b0;
		in_valid = valid;
		in_type3 = type3;
		in_meta = m;
		in_ras = r;
		pending.push_back(e);
		void'(pending.pop_front());
	endtask

	task automatic idle();
		step(1'b0, 1'b0, '0, '0);
	endtask

	task automatic load_policies(input mask_on_t force_bits);
		logic [31:0] rnd;
		policy_t p;
		for (int i = 0; i < 16; i++) begin
			idle();
			rnd = $random(seed);
			p = rnd[$bits(policy_t)-1:0];
			p.mask_on = p.mask_on | force_bits;
			policy_wr = 1'b1;
			policy_addr = i[3:0];
			policy_data = p;
			pol_m[i] = p;
		end
		idle();
		idle();
	endtask

	task automatic make_packet(input int mode, output logic type3, output meta_t m,
			output ras_t r);
		logic [63:0] rnd;
		int kind;
		rnd = {$random(seed), $random(seed)};
		m = rnd[$bits(meta_t)-1:0];
		rnd = {$random(seed), $random(seed)};
		r = rnd[$bits(ras_t)-1:0];
		type3 = 1'b0;
		m.discard = 1'b0;
		m.type1 = 1'b0;
		case (mode)
			1: r.flags.exec_flow = 1'b1;
			2: begin
				// Few flows, so later packets look at the entries a drop left alone.
				m.fid[3:2] = 2'b00;
				r.flags.keep_flow = 1'b1;
				r.flags.exec_flow = 1'b1;
				r.flags.allow_update = 1'b1;
				r.flags.set_default = 1'b1;
				kind = $unsigned($random(seed)) % 4;
				if (kind == 0) begin
					m.discard = 1'b1;
				end else if (kind == 1) begin
					m.type1 = 1'b1;
					do m.domain_id = $random(seed);
					while (m.domain_id == 4'h0 || m.domain_id == pol_m[m.fid].domain_id);
				end else if (kind == 2) begin
					r.flags.exec_flow = 1'b0;
					r.flags.exec_topic = 1'b0;
					r.flags.set_default = 1'b0;
				end else begin
					type3 = 1'b1;
				end
			end
			3: begin
				m.fid = 4'd5;
				m.tid = 4'd9;
				r.flags.keep_flow = 1'b1;
				r.flags.exec_flow = 1'b1;
				r.flags.exec_topic = 1'b1;
			end
			4: begin
				m.fid[3:2] = 2'b00;
				r.flags.keep_flow = 1'b1;
				type3 = rnd[63];
			end
			5: begin
				r.flags.exec_flow = 1'b1;
				for (int i = 0; i < 8; i++)
					r.flow[i].invalid = ($random(seed) % 4 == 0);
			end
			default: begin
				r.flags.exec_topic = 1'b1;
				r.topic.invalid = ($random(seed) % 8 == 0);
			end
		endcase
	endtask

	task automatic run_test(input int num, input string name, input int mode,
			input mask_on_t force_bits);
		int errors_before;
		int checks_before;
		logic type3;
		meta_t m;
		ras_t r;
		errors_before = errors;
		checks_before = checks;
		load_policies(force_bits);
		for (int i = 0; i < num_packets; i++) begin
			if (mode != 3 && $random(seed) % 4 == 0)
				idle();
			make_packet(mode, type3, m, r);
			step(1'b1, type3, m, r);
		end
		repeat (4) idle();
		$display("Test %0d, %s: %0d checks, %0d errors", num, name,
			checks - checks_before, errors - errors_before);
	endtask

	initial begin
		reset = 1'b1;
		policy_wr = 1'b0;
		policy_addr = '0;
		policy_data = '0;
		in_valid = 1'b0;
		in_type3 = 1'b0;
		in_meta = '0;
		in_ras = '0;
		supervisor_sci = $random(seed);
		class2pri = $random(seed);
		default_sub_exp_time = $random(seed);
		current_time = $random(seed);
		for (int i = 0; i < 16; i++) begin
			pol_m[i] = '0;
			fa_m[i] = '0;
			ta_m[i] = '0;
		end
		repeat (3) pending.push_back('0);
		no_bits = '0;
		fas_bits = '0;
		fas_bits.allow_update_fas = 1'b1;
		tas_bits = '0;
		tas_bits.allow_update_tas = 1'b1;
		learn_bits = fas_bits | tas_bits;
		learn_bits.allow_exec_forward = 1'b1;
		learn_bits.allow_fsas_forward = 1'b1;
		learn_bits.allow_tsas_forward = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_test(1, "policy loading and forwarding", 1, no_bits);
		run_test(2, "discards", 2, fas_bits | tas_bits);
		run_test(3, "back-to-back learning", 3, learn_bits);
		run_test(4, "type 3 forwarding", 4, fas_bits);
		run_test(5, "ingress and supervisor masks", 5, no_bits);
		run_test(6, "timer set and classifier", 6, tas_bits);
		// Assertion failures of the bound checker count as errors too.
		errors = errors + UUT.decide.checks.fail_count;
		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
//##########################################################################
// Free-running testbench clock. It starts low, and the period must be even.
//##########################################################################
`default_nettype none

module tb_clock_gen #(
	parameter int period = 40
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire
